//--- logic/fpu_macros.svh
// fpu widths and encodings
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

`define FP_XLEN        64
`define FP_TAG_W       5
`define FP_CTRL_W      7

// control field positions
`define FP_CTRL_FMT_HI 6
`define FP_CTRL_FMT_LO 5
`define FP_CTRL_MULT   4
`define FP_CTRL_OP_HI  3
`define FP_IMM_DIR     15    // 1 = integer to float

`define FP_OP_FSGN     4'd5
`define FP_OP_MINMAX   4'd6
`define FP_OP_CMP      4'd12
`define FP_OP_CLASS    4'd13
`define FP_OP_FMV      4'd14

`define FP_S_BOX       32'hffff_ffff
`define FP_S_EXP_MAX   8'hff
`define FP_D_EXP_MAX   11'h7ff
`define FP_S_QNAN      64'hffff_ffff_7fc0_0000    // boxed
`define FP_D_QNAN      64'h7ff8_0000_0000_0000

`endif

//--- logic/fpu_pkg.sv
// fpu shared types
`include "fpu_macros.svh"

package fpu_pkg;

	// op field, control bits 3..0
	typedef enum logic [3:0] {
		OP_FSGN   = `FP_OP_FSGN,
		OP_MINMAX = `FP_OP_MINMAX,
		OP_CMP    = `FP_OP_CMP,
		OP_CLASS  = `FP_OP_CLASS,
		OP_FMV    = `FP_OP_FMV
	} fp_op_t;

	// size field, other codes unsupported
	typedef enum logic [1:0] {
		FMT_S = 2'd0,
		FMT_D = 2'd1
	} fp_fmt_t;

	typedef struct packed {
		logic nv;    // invalid
		logic dz;
		logic of;
		logic uf;
		logic nx;
	} fp_flags_t;

	// operand in double layout
	typedef struct packed {
		logic        sign;
		logic [10:0] exp;     // single rebiased
		logic [51:0] man;     // left aligned
		logic        nan;
		logic        snan;
		logic        inf;
		logic        zero;
		logic        sub;
	} fp_operand_t;

endpackage

//--- logic/fp_operand_decode.sv
// fp operand decoder
`include "fpu_macros.svh"

module fp_operand_decode (
	input  fpu_pkg::fp_fmt_t      fmt,
	input  logic [`FP_XLEN-1:0]   value,
	output fpu_pkg::fp_operand_t  opnd
);
	import fpu_pkg::*;

	logic        boxed;
	logic [7:0]  s_exp;
	logic [22:0] s_man;
	logic        exp_max;
	logic        exp_zero;
	logic        man_zero;

	assign boxed = value[63:32] == `FP_S_BOX;
	assign s_exp = value[30:23];
	assign s_man = value[22:0];

	always_comb begin
		if (fmt == FMT_S) begin
			exp_max  = s_exp == `FP_S_EXP_MAX;
			exp_zero = s_exp == 8'h00;
			man_zero = s_man == 23'h0;
			opnd.sign = value[31];
			if (exp_max)
				opnd.exp = `FP_D_EXP_MAX;
			else if (exp_zero)
				opnd.exp = 11'h000;
			else
				opnd.exp = {s_exp[7], {3{~s_exp[7]}}, s_exp[6:0]};    // bias 127 -> 1023
			opnd.man = {s_man, 29'h0};
		end else begin
			exp_max  = value[62:52] == `FP_D_EXP_MAX;
			exp_zero = value[62:52] == 11'h000;
			man_zero = value[51:0] == 52'h0;
			opnd.sign = value[63];
			opnd.exp  = value[62:52];
			opnd.man  = value[51:0];
		end

		opnd.nan  = exp_max && !man_zero;
		opnd.snan = opnd.nan && !opnd.man[51];    // quiet bit clear
		opnd.inf  = exp_max && man_zero;
		opnd.zero = exp_zero && man_zero;
		opnd.sub  = exp_zero && !man_zero;

		// broken box reads as the canonical quiet nan
		if (fmt == FMT_S && !boxed) begin
			opnd.sign = 1'b0;
			opnd.exp  = `FP_D_EXP_MAX;
			opnd.man  = {1'b1, 51'h0};
			opnd.nan  = 1'b1;
			opnd.snan = 1'b0;
			opnd.inf  = 1'b0;
			opnd.zero = 1'b0;
			opnd.sub  = 1'b0;
		end
	end

endmodule

//--- logic/fp_compare.sv
// fp compare and min/max
`include "fpu_macros.svh"

module fp_compare (
	input  logic [2:0]            funct3,
	input  logic [`FP_XLEN-1:0]   fr1,
	input  logic [`FP_XLEN-1:0]   fr2,
	input  fpu_pkg::fp_operand_t  a,
	input  fpu_pkg::fp_operand_t  b,
	input  fpu_pkg::fp_fmt_t      fmt,
	input  fpu_pkg::fp_op_t       op,
	output logic [`FP_XLEN-1:0]   cmp_res,
	output logic                  cmp_is_fp,
	output fpu_pkg::fp_flags_t    flags
);
	import fpu_pkg::*;

	logic                eq;
	logic                lt;
	logic                any_nan;
	logic                any_snan;
	logic                cmp_bit;
	logic                pick_a;
	logic [`FP_XLEN-1:0] minmax_res;

	assign any_nan  = a.nan | b.nan;
	assign any_snan = a.snan | b.snan;

	// ordering of a against b, meaningless when a nan is present
	always_comb begin
		if (a.sign != b.sign) begin
			eq = a.zero && b.zero;    // -0 == +0
			lt = a.sign && !eq;
		end else if (a.inf || b.inf) begin
			eq = a.inf && b.inf;
			lt = !eq && !(a.inf ^ a.sign);
		end else if (a.exp != b.exp) begin
			eq = 1'b0;
			lt = (a.exp < b.exp) ^ a.sign;
		end else if (a.man != b.man) begin
			eq = 1'b0;
			lt = (a.man < b.man) ^ a.sign;
		end else begin
			eq = 1'b1;
			lt = 1'b0;
		end
	end

	always_comb begin
		case (funct3)
			3'd0:    cmp_bit = eq || lt;    // fle
			3'd1:    cmp_bit = lt;          // flt
			3'd2:    cmp_bit = eq;          // feq
			default: cmp_bit = 1'b0;
		endcase
		if (any_nan)
			cmp_bit = 1'b0;
	end

	// funct3[0] selects max; on a tie min takes the negative one
	assign pick_a = (eq ? a.sign : lt) ^ funct3[0];

	always_comb begin
		case ({a.nan, b.nan})
			2'b00:   minmax_res = pick_a ? fr1 : fr2;
			2'b01:   minmax_res = fr1;
			2'b10:   minmax_res = fr2;
			default: minmax_res = (fmt == FMT_S) ? `FP_S_QNAN : `FP_D_QNAN;
		endcase
	end

	always_comb begin
		flags     = '0;
		cmp_res   = {{(`FP_XLEN-1){1'b0}}, cmp_bit};
		cmp_is_fp = 1'b0;
		case (op)
			OP_MINMAX: begin
				cmp_res   = minmax_res;
				cmp_is_fp = 1'b1;
				flags.nv  = any_snan;
			end
			OP_CMP: flags.nv = (funct3 == 3'd2) ? any_snan : any_nan;    // feq is quiet
			default: flags.nv = 1'b0;
		endcase
	end

	// invalid only ever traces back to a nan flagged by a decoder
	always_comb begin
		assert final (!flags.nv || a.nan || b.nan)
			else $error("fp_compare: nv raised without a nan operand");
	end

endmodule

//--- logic/fp_sign_move.sv
// sign injection and fmv
`include "fpu_macros.svh"

module fp_sign_move (
	input  fpu_pkg::fp_fmt_t     fmt,
	input  logic [2:0]           funct3,
	input  logic                 to_int,
	input  logic [`FP_XLEN-1:0]  fr1,
	input  logic [`FP_XLEN-1:0]  fr2,
	input  logic [`FP_XLEN-1:0]  ir1,
	output logic [`FP_XLEN-1:0]  sign_res,
	output logic                 sign_is_fp
);
	import fpu_pkg::*;

	localparam logic [`FP_XLEN-1:0] s_qnan = `FP_S_QNAN;

	logic [31:0] s1;
	logic [31:0] s2;
	logic        src_sign;
	logic        tgt_sign;
	logic        new_sign;

	// singles with a broken box act as canonical nan
	assign s1 = (fr1[63:32] == `FP_S_BOX) ? fr1[31:0] : s_qnan[31:0];
	assign s2 = (fr2[63:32] == `FP_S_BOX) ? fr2[31:0] : s_qnan[31:0];

	always_comb begin
		src_sign = (fmt == FMT_S) ? s2[31] : fr2[63];
		tgt_sign = (fmt == FMT_S) ? s1[31] : fr1[63];
		case (funct3[1:0])
			2'd1:    new_sign = ~src_sign;            // fsgnjn
			2'd2:    new_sign = src_sign ^ tgt_sign;  // fsgnjx
			default: new_sign = src_sign;             // fsgnj
		endcase

		if (funct3[2]) begin    // fmv
			sign_is_fp = !to_int;
			if (to_int)
				sign_res = (fmt == FMT_S) ? {{32{fr1[31]}}, fr1[31:0]} : fr1;
			else
				sign_res = (fmt == FMT_S) ? {`FP_S_BOX, ir1[31:0]} : ir1;
		end else begin
			sign_is_fp = 1'b1;
			if (fmt == FMT_S)
				sign_res = {`FP_S_BOX, new_sign, s1[30:0]};
			else
				sign_res = {new_sign, fr1[62:0]};
		end
	end

endmodule

//--- logic/fp_classify.sv
// fclass mask
`include "fpu_macros.svh"

module fp_classify (
	input  fpu_pkg::fp_operand_t  a,
	input  fpu_pkg::fp_fmt_t      fmt,
	output logic [`FP_XLEN-1:0]   class_res
);
	import fpu_pkg::*;

	logic       normal;
	logic       fmt_ok;
	logic [9:0] mask;

	assign normal = !(a.nan | a.inf | a.zero | a.sub);
	assign fmt_ok = (fmt == FMT_S) || (fmt == FMT_D);

	assign mask = {
		a.nan & !a.snan,     // quiet nan
		a.snan,
		!a.sign & a.inf,
		!a.sign & normal,
		!a.sign & a.sub,
		!a.sign & a.zero,
		a.sign & a.zero,
		a.sign & a.sub,
		a.sign & normal,
		!a.nan & a.sign & a.inf
	};

	assign class_res = fmt_ok ? {{(`FP_XLEN-10){1'b0}}, mask} : '0;

	// decoder flags must leave exactly one class
	always_comb begin
		assert final (!fmt_ok || $onehot(class_res))
			else $error("fp_classify: class mask not one-hot");
	end

endmodule

//--- logic/fp_issue_wb.sv
// issue and writeback stage
`include "fpu_macros.svh"

module fp_issue_wb (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   enable,
	input  logic [`FP_CTRL_W-1:0]  control,
	input  logic [15:12]           immed,
	input  logic [`FP_TAG_W-1:0]   rd,
	input  logic [`FP_XLEN-1:0]    sign_res,
	input  logic                   sign_is_fp,
	input  logic [`FP_XLEN-1:0]    cmp_res,
	input  logic                   cmp_is_fp,
	input  fpu_pkg::fp_flags_t     cmp_flags,
	input  logic [`FP_XLEN-1:0]    class_res,
	output fpu_pkg::fp_fmt_t       fmt,
	output fpu_pkg::fp_op_t        op,
	output logic [2:0]             funct3,
	output logic                   to_int,
	output logic [`FP_XLEN-1:0]    result,
	output logic [`FP_TAG_W-1:0]   res_rd,
	output logic                   res_makes_rd,
	output logic                   res_makes_fp,
	output fpu_pkg::fp_flags_t     res_exceptions
);
	import fpu_pkg::*;

	logic                 start;
	fp_op_t               r_op;
	fp_fmt_t              r_fmt;
	logic                 r_multiple;
	logic [2:0]           r_funct3;
	logic                 r_dir;
	logic [`FP_TAG_W-1:0] r_rd;
	logic                 supported;
	logic                 wb_valid;
	logic [`FP_XLEN-1:0]  sel_res;
	logic                 sel_fp;
	fp_flags_t            sel_flags;

	always_ff @(posedge clk) begin
		if (!rst_n)
			start <= 1'b0;
		else
			start <= enable;
	end

	always_ff @(posedge clk) begin
		if (enable) begin
			r_op       <= fp_op_t'(control[`FP_CTRL_OP_HI:0]);
			r_fmt      <= fp_fmt_t'(control[`FP_CTRL_FMT_HI:`FP_CTRL_FMT_LO]);
			r_multiple <= control[`FP_CTRL_MULT];
			r_funct3   <= immed[14:12];
			r_dir      <= immed[`FP_IMM_DIR];
			r_rd       <= rd;
		end
	end

	assign fmt    = r_fmt;
	assign op     = r_op;
	assign funct3 = {r_funct3[2] | (r_op == OP_FMV), r_funct3[1:0]};    // bit 2 marks fmv
	assign to_int = !r_dir;

	always_comb begin
		case (r_op)
			OP_FSGN, OP_MINMAX, OP_CMP, OP_CLASS, OP_FMV:
				supported = !r_multiple && (r_fmt == FMT_S || r_fmt == FMT_D);
			default:
				supported = 1'b0;    // fadd etc
		endcase
	end

	assign wb_valid = start && supported;

	// one unit per op
	always_comb begin
		sel_res   = sign_res;
		sel_fp    = sign_is_fp;
		sel_flags = '0;
		case (r_op)
			OP_MINMAX, OP_CMP: begin
				sel_res   = cmp_res;
				sel_fp    = cmp_is_fp;
				sel_flags = cmp_flags;
			end
			OP_CLASS: begin
				sel_res = class_res;
				sel_fp  = 1'b0;
			end
			default: sel_fp = sign_is_fp;    // fsgn, fmv
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res_makes_rd <= 1'b0;
			res_makes_fp <= 1'b0;
		end else begin
			res_makes_rd <= wb_valid;
			res_makes_fp <= wb_valid && sel_fp;
		end
	end

	always_ff @(posedge clk) begin
		result         <= sel_res;
		res_rd         <= r_rd;
		res_exceptions <= sel_flags;
	end

	// a writeback is always one cycle behind its issue
	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(res_makes_rd) |-> $past(start))
		else $error("fp_issue_wb: writeback without a started command");

endmodule

//--- logic/fpu_top.sv
// single cycle fpu top
`include "fpu_macros.svh"

module fpu_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   enable,
	input  logic [`FP_CTRL_W-1:0]  control,
	input  logic [15:12]           immed,
	input  logic [`FP_TAG_W-1:0]   rd,
	input  logic [`FP_XLEN-1:0]    fr1,
	input  logic [`FP_XLEN-1:0]    fr2,
	input  logic [`FP_XLEN-1:0]    ir1,
	output logic [`FP_XLEN-1:0]    result,
	output logic [`FP_TAG_W-1:0]   res_rd,
	output logic                   res_makes_rd,
	output logic                   res_makes_fp,
	output fpu_pkg::fp_flags_t     res_exceptions
);
	import fpu_pkg::*;

	fp_fmt_t             fmt;
	fp_op_t              op;
	logic [2:0]          funct3;
	logic                to_int;
	fp_operand_t         opnd_a;
	fp_operand_t         opnd_b;
	logic [`FP_XLEN-1:0] sign_res;
	logic                sign_is_fp;
	logic [`FP_XLEN-1:0] cmp_res;
	logic                cmp_is_fp;
	fp_flags_t           cmp_flags;
	logic [`FP_XLEN-1:0] class_res;

	fp_issue_wb issue_wb_i (
		.clk(clk), .rst_n(rst_n), .enable(enable),
		.control(control), .immed(immed), .rd(rd),
		.sign_res(sign_res), .sign_is_fp(sign_is_fp),
		.cmp_res(cmp_res), .cmp_is_fp(cmp_is_fp), .cmp_flags(cmp_flags),
		.class_res(class_res),
		.fmt(fmt), .op(op), .funct3(funct3), .to_int(to_int),
		.result(result), .res_rd(res_rd), .res_makes_rd(res_makes_rd),
		.res_makes_fp(res_makes_fp), .res_exceptions(res_exceptions)
	);

	fp_operand_decode decode_a_i (.fmt(fmt), .value(fr1), .opnd(opnd_a));
	fp_operand_decode decode_b_i (.fmt(fmt), .value(fr2), .opnd(opnd_b));

	fp_compare compare_i (
		.funct3(funct3), .fr1(fr1), .fr2(fr2), .a(opnd_a), .b(opnd_b),
		.fmt(fmt), .op(op),
		.cmp_res(cmp_res), .cmp_is_fp(cmp_is_fp), .flags(cmp_flags)
	);

	fp_sign_move sign_move_i (
		.fmt(fmt), .funct3(funct3), .to_int(to_int),
		.fr1(fr1), .fr2(fr2), .ir1(ir1),
		.sign_res(sign_res), .sign_is_fp(sign_is_fp)
	);

	fp_classify classify_i (.a(opnd_a), .fmt(fmt), .class_res(class_res));

endmodule

//--- tb/fpu_tb.sv
// fpu execute unit testbench
`include "fpu_macros.svh"

module fpu_tb;
	import fpu_pkg::*;

	localparam logic [1:0] F_S = 2'd0;
	localparam logic [1:0] F_D = 2'd1;
	localparam logic [1:0] F_H = 2'd2;    // half, not kept

	localparam logic [63:0] D_ONE  = 64'h3ff0_0000_0000_0000;
	localparam logic [63:0] D_MONE = 64'hbff0_0000_0000_0000;
	localparam logic [63:0] D_TWO  = 64'h4000_0000_0000_0000;
	localparam logic [63:0] D_MTWO = 64'hc000_0000_0000_0000;
	localparam logic [63:0] D_PZ   = 64'h0000_0000_0000_0000;
	localparam logic [63:0] D_NZ   = 64'h8000_0000_0000_0000;
	localparam logic [63:0] D_PINF = 64'h7ff0_0000_0000_0000;
	localparam logic [63:0] D_NINF = 64'hfff0_0000_0000_0000;
	localparam logic [63:0] D_QNAN = 64'h7ff8_0000_0000_0000;
	localparam logic [63:0] D_SNAN = 64'h7ff0_0000_0000_0001;
	localparam logic [63:0] D_SUB  = 64'h0000_0000_0000_0001;
	localparam logic [63:0] D_NSUB = 64'h8000_0000_0000_0001;
	localparam logic [63:0] S_ONE  = 64'hffff_ffff_3f80_0000;
	localparam logic [63:0] S_MONE = 64'hffff_ffff_bf80_0000;
	localparam logic [63:0] S_TWO  = 64'hffff_ffff_4000_0000;
	localparam logic [63:0] S_MTWO = 64'hffff_ffff_c000_0000;
	localparam logic [63:0] S_QNAN = 64'hffff_ffff_7fc0_0000;
	localparam logic [63:0] S_SNAN = 64'hffff_ffff_7f80_0001;
	localparam logic [63:0] S_NOBOX = 64'h0000_0000_3f80_0000;    // upper half not all ones

	typedef struct packed {
		logic [`FP_CTRL_W-1:0] control;
		logic [3:0]            immed;
		logic [`FP_TAG_W-1:0]  rd;
		logic [63:0]           fr1;
		logic [63:0]           fr2;
		logic [63:0]           ir1;
		logic [63:0]           exp_res;
		logic                  exp_makes_rd;
		logic                  exp_makes_fp;
		logic [4:0]            exp_flags;
	} vec_t;

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic                  enable;
	logic [`FP_CTRL_W-1:0] control;
	logic [15:12]          immed;
	logic [`FP_TAG_W-1:0]  rd;
	logic [`FP_XLEN-1:0]   fr1;
	logic [`FP_XLEN-1:0]   fr2;
	logic [`FP_XLEN-1:0]   ir1;
	logic [`FP_XLEN-1:0]   result;
	logic [`FP_TAG_W-1:0]  res_rd;
	logic                  res_makes_rd;
	logic                  res_makes_fp;
	fp_flags_t             res_exceptions;

	vec_t        vecs[$];
	logic [63:0] d_class [10];
	logic [63:0] s_class [10];
	int          errors = 0;
	int          checks = 0;

	fpu_top fpu_top_i (.*);

	always #50 clk = ~clk;

	// rd tag picked at random
	// bits = {makes_rd, makes_fp, nv}
	task automatic push_case(input logic [1:0] fmt, input logic [3:0] op, input logic [2:0] f3,
			input logic dir, input logic [63:0] a, input logic [63:0] b, input logic [63:0] ir,
			input logic [63:0] res, input logic [2:0] bits);
		vec_t        v;
		logic [31:0] r;
		r = $urandom;
		v.control      = {fmt, 1'b0, op};
		v.immed        = {dir, f3};
		v.rd           = r[4:0];
		v.fr1          = a;
		v.fr2          = b;
		v.ir1          = ir;
		v.exp_res      = res;
		v.exp_makes_rd = bits[2];
		v.exp_makes_fp = bits[1];
		v.exp_flags    = {bits[0], 4'b0000};
		vecs.push_back(v);
	endtask

	task automatic build_table();
		logic [63:0] rnd;
		logic [63:0] wneg;
		d_class = '{D_NINF, D_MONE, D_NSUB, D_NZ, D_PZ, D_SUB, D_ONE, D_PINF, D_SNAN, D_QNAN};
		s_class = '{64'hffff_ffff_ff80_0000, S_MONE, 64'hffff_ffff_8000_0001,
			64'hffff_ffff_8000_0000, 64'hffff_ffff_0000_0000, 64'hffff_ffff_0000_0001,
			S_ONE, 64'hffff_ffff_7f80_0000, S_SNAN, S_QNAN};
		// sign injection
		push_case(F_S, OP_FSGN, 3'd0, 1'b0, S_ONE, S_MTWO, 64'd0, S_MONE, 3'b110);
		push_case(F_S, OP_FSGN, 3'd1, 1'b0, S_MONE, S_MTWO, 64'd0, S_ONE, 3'b110);
		push_case(F_S, OP_FSGN, 3'd2, 1'b0, S_MONE, S_MTWO, 64'd0, S_ONE, 3'b110);
		push_case(F_S, OP_FSGN, 3'd0, 1'b0, S_NOBOX, S_MTWO, 64'd0,
			64'hffff_ffff_ffc0_0000, 3'b110);
		push_case(F_D, OP_FSGN, 3'd1, 1'b0, D_MONE, D_MONE, 64'd0, D_ONE, 3'b110);
		push_case(F_D, OP_FSGN, 3'd2, 1'b0, D_MONE, D_TWO, 64'd0, D_MONE, 3'b110);
		push_case(F_D, 4'd0, 3'd0, 1'b0, D_ONE, D_TWO, 64'd0, 64'd0, 3'b000);    // fadd
		// compares
		push_case(F_D, OP_CMP, 3'd0, 1'b0, D_ONE, D_TWO, 64'd0, 64'd1, 3'b100);
		push_case(F_D, OP_CMP, 3'd1, 1'b0, D_MTWO, D_MONE, 64'd0, 64'd1, 3'b100);
		push_case(F_D, OP_CMP, 3'd2, 1'b0, D_NZ, D_PZ, 64'd0, 64'd1, 3'b100);
		push_case(F_D, OP_CMP, 3'd1, 1'b0, D_NZ, D_PZ, 64'd0, 64'd0, 3'b100);
		push_case(F_D, OP_CMP, 3'd1, 1'b0, D_NINF, D_PINF, 64'd0, 64'd1, 3'b100);
		push_case(F_D, OP_CMP, 3'd2, 1'b0, D_PINF, D_PINF, 64'd0, 64'd1, 3'b100);
		push_case(F_D, OP_CMP, 3'd0, 1'b0, D_PINF, D_TWO, 64'd0, 64'd0, 3'b100);
		push_case(F_D, OP_CMP, 3'd2, 1'b0, D_QNAN, D_ONE, 64'd0, 64'd0, 3'b100);
		push_case(F_D, OP_CMP, 3'd1, 1'b0, D_QNAN, D_ONE, 64'd0, 64'd0, 3'b101);
		push_case(F_D, OP_CMP, 3'd2, 1'b0, D_SNAN, D_ONE, 64'd0, 64'd0, 3'b101);
		push_case(F_S, OP_CMP, 3'd1, 1'b0, S_ONE, S_TWO, 64'd0, 64'd1, 3'b100);
		push_case(F_S, OP_CMP, 3'd2, 1'b0, S_NOBOX, S_ONE, 64'd0, 64'd0, 3'b100);
		push_case(F_H, OP_FSGN, 3'd0, 1'b0, S_ONE, S_TWO, 64'd0, 64'd0, 3'b000);
		// min and max
		push_case(F_D, OP_MINMAX, 3'd1, 1'b0, D_ONE, D_TWO, 64'd0, D_TWO, 3'b110);
		push_case(F_D, OP_MINMAX, 3'd0, 1'b0, D_QNAN, D_TWO, 64'd0, D_TWO, 3'b110);
		push_case(F_D, OP_MINMAX, 3'd1, 1'b0, D_ONE, D_SNAN, 64'd0, D_ONE, 3'b111);
		push_case(F_D, OP_MINMAX, 3'd0, 1'b0, D_QNAN, D_SNAN, 64'd0, D_QNAN, 3'b111);
		push_case(F_D, OP_MINMAX, 3'd0, 1'b0, D_PZ, D_NZ, 64'd0, D_NZ, 3'b110);
		push_case(F_D, OP_MINMAX, 3'd1, 1'b0, D_NZ, D_PZ, 64'd0, D_PZ, 3'b110);
		push_case(F_S, OP_MINMAX, 3'd1, 1'b0, S_QNAN, S_SNAN, 64'd0, S_QNAN, 3'b111);
		push_case(F_S, OP_MINMAX, 3'd0, 1'b0, S_NOBOX, S_MONE, 64'd0, S_MONE, 3'b110);
		push_case(F_S, OP_MINMAX, 3'd0, 1'b0, S_ONE, S_TWO, 64'd0, 64'd0, 3'b000);
		vecs[vecs.size()-1].control[4] = 1'b1;    // multiple-op bit kills it
		// class bit i for table entry i
		for (int i = 0; i < 10; i++) begin
			push_case(F_D, OP_CLASS, 3'd1, 1'b0, d_class[i], 64'd0, 64'd0, 64'd1 << i, 3'b100);
			push_case(F_S, OP_CLASS, 3'd1, 1'b0, s_class[i], 64'd0, 64'd0, 64'd1 << i, 3'b100);
		end
		push_case(F_S, OP_CLASS, 3'd1, 1'b0, S_NOBOX, 64'd0, 64'd0, 64'h200, 3'b100);
		// moves as a double round trip then single
		rnd  = {$urandom, $urandom};
		wneg = {$urandom, 1'b1, rnd[30:0]};
		push_case(F_D, OP_FMV, 3'd0, 1'b1, 64'd0, 64'd0, rnd, rnd, 3'b110);
		push_case(F_D, OP_FMV, 3'd0, 1'b0, rnd, 64'd0, 64'd0, rnd, 3'b100);
		push_case(F_S, OP_FMV, 3'd0, 1'b0, wneg, 64'd0, 64'd0,
			{32'hffff_ffff, wneg[31:0]}, 3'b100);
		push_case(F_S, OP_FMV, 3'd0, 1'b1, 64'd0, 64'd0, rnd,
			{32'hffff_ffff, rnd[31:0]}, 3'b110);
	endtask

	task automatic compare_value(input string name, input int idx, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch %s in vector %0d: got %h, expected %h", name, idx, got, exp);
			errors++;
		end
	endtask

	task automatic check_vector(input int idx);
		vec_t v;
		v = vecs[idx];
		compare_value("res_makes_rd", idx, {63'd0, res_makes_rd}, {63'd0, v.exp_makes_rd});
		compare_value("res_makes_fp", idx, {63'd0, res_makes_fp}, {63'd0, v.exp_makes_fp});
		if (v.exp_makes_rd) begin    // data only matters with a writeback
			compare_value("result", idx, result, v.exp_res);
			compare_value("res_rd", idx, {59'd0, res_rd}, {59'd0, v.rd});
			compare_value("res_exceptions", idx, {59'd0, res_exceptions}, {59'd0, v.exp_flags});
		end
	endtask

	initial begin
		int n;
		int wait_cycles;
		void'($urandom(17630));
		rst_n   = 1'b0;
		enable  = 1'b1;    // a command pending in reset must not start
		control = {F_D, 1'b0, OP_CLASS};
		immed   = 4'b0001;
		rd      = '0;
		fr1     = '0;
		fr2     = '0;
		ir1     = '0;
		build_table();
		n = vecs.size();
		repeat (16) @(posedge clk);
		#1;
		rst_n  = 1'b1;
		enable = 1'b0;
		for (int i = 0; i < 4; i++) begin    // idle after reset
			@(posedge clk);
			#1;
			compare_value("res_makes_rd", -1, {63'd0, res_makes_rd}, 64'd0);
			compare_value("res_makes_fp", -1, {63'd0, res_makes_fp}, 64'd0);
		end
		// command k goes out in cycle k, its operands in k+1, outputs seen in k+2
		for (int k = 0; k < n + 2; k++) begin
			@(posedge clk);
			#1;
			if (k >= 2)
				check_vector(k - 2);
			enable = k < n;
			if (k < n) begin
				control = vecs[k].control;
				immed   = vecs[k].immed;
				rd      = vecs[k].rd;
			end
			if (k >= 1 && k <= n) begin
				fr1 = vecs[k-1].fr1;
				fr2 = vecs[k-1].fr2;
				ir1 = vecs[k-1].ir1;
			end
		end
		wait_cycles = 0;
		while (res_makes_rd && wait_cycles < 20) begin
			@(posedge clk);
			#1;
			wait_cycles++;
		end
		if (res_makes_rd) begin
			$display("Timeout: writeback still active after the last vector");
			errors++;
		end
		$display("%0d errors in %0d checks over %0d vectors", errors, checks, n);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- all.f
+incdir+logic
logic/fpu_pkg.sv
logic/fp_operand_decode.sv
logic/fp_compare.sv
logic/fp_sign_move.sv
logic/fp_classify.sv
logic/fp_issue_wb.sv
logic/fpu_top.sv
tb/fpu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -sv -f all.f --top-module fpu_tb -Mdir obj_dir -o fpu_sim

./obj_dir/fpu_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx 'Done: no errors' sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
